// File: Makefile
VERILATOR  := verilator
TOP        := valu_tb
FILELIST   := valu.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/valu_decode.sv
`default_nettype none

module valu_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  valu_pkg::func_t   req_func_id,
    input  valu_pkg::sew_t    req_sew,
    input  valu_pkg::data_t   req_data0,
    input  valu_pkg::data_t   req_data1,
    output logic              dec_valid,
    output valu_pkg::alu_op_e dec_op,
    output logic              dec_signed,
    output logic              dec_arith_shift,
    output valu_pkg::sew_t    dec_sew,
    output valu_pkg::data_t   dec_data0,
    output valu_pkg::data_t   dec_data1
);

    valu_pkg::alu_op_e op_next;
    logic              signed_next;
    logic              arith_next;

    // function code to operation class.
    always_comb begin
        op_next     = valu_pkg::OP_NONE;
        signed_next = 1'b0;
        arith_next  = 1'b0;
        case (req_func_id)
            valu_pkg::FUNC_ADD:  op_next = valu_pkg::OP_ADD;
            valu_pkg::FUNC_SUB:  op_next = valu_pkg::OP_SUB;
            valu_pkg::FUNC_MINU: op_next = valu_pkg::OP_MIN;
            valu_pkg::FUNC_MIN: begin
                op_next     = valu_pkg::OP_MIN;
                signed_next = 1'b1;
            end
            valu_pkg::FUNC_MAXU: op_next = valu_pkg::OP_MAX;
            valu_pkg::FUNC_MAX: begin
                op_next     = valu_pkg::OP_MAX;
                signed_next = 1'b1;
            end
            valu_pkg::FUNC_AND:  op_next = valu_pkg::OP_AND;
            valu_pkg::FUNC_OR:   op_next = valu_pkg::OP_OR;
            valu_pkg::FUNC_XOR:  op_next = valu_pkg::OP_XOR;
            valu_pkg::FUNC_SLL:  op_next = valu_pkg::OP_SHL;
            valu_pkg::FUNC_SRL:  op_next = valu_pkg::OP_SHR;
            valu_pkg::FUNC_SRA: begin
                op_next     = valu_pkg::OP_SHR;
                signed_next = 1'b1;
                arith_next  = 1'b1;
            end
            default: op_next = valu_pkg::OP_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    // operands and decoded fields only move with a request.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec_op          <= op_next;
            dec_signed      <= signed_next;
            dec_arith_shift <= arith_next;
            dec_sew         <= req_sew;
            dec_data0       <= req_data0;
            dec_data1       <= req_data1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/valu_execute.sv
`default_nettype none

module valu_execute (
    input  logic              clk,
    input  logic              rst,
    input  logic              dec_valid,
    input  valu_pkg::alu_op_e dec_op,
    input  logic              dec_signed,
    input  logic              dec_arith_shift,
    input  valu_pkg::sew_t    dec_sew,
    input  valu_pkg::data_t   dec_data0,
    input  valu_pkg::data_t   dec_data1,
    output logic              ex_valid,
    output logic              ex_op_ok,
    output valu_pkg::data_t   ex_result
);

    // one full result word per element width, picked by dec_sew below.
    valu_pkg::data_t sew_result [4];
    valu_pkg::data_t result_next;

    ////////////////////////////////////////////////////////////////////////////
    // per element lanes
    ////////////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int EW      = 8 << s;
        localparam int SH_BITS = 3 + s;

        for (genvar e = 0; e < 64 / EW; e++) begin : g_elem
            logic [EW-1:0]      a;
            logic [EW-1:0]      b;
            logic [EW-1:0]      r;
            logic signed [EW:0] a_ext;
            logic signed [EW:0] b_ext;
            logic signed [EW:0] shr_ext;
            logic               lt;
            logic [SH_BITS-1:0] shamt;

            assign a = dec_data0[e*EW +: EW];
            assign b = dec_data1[e*EW +: EW];

            always_comb begin
                // extra top bit makes one comparator serve both orderings.
                a_ext   = {dec_signed & a[EW-1], a};
                b_ext   = {dec_signed & b[EW-1], b};
                lt      = a_ext < b_ext;
                shamt   = b[SH_BITS-1:0];
                shr_ext = $signed({dec_arith_shift & a[EW-1], a}) >>> shamt;
                case (dec_op)
                    valu_pkg::OP_ADD: r = a + b;
                    valu_pkg::OP_SUB: r = a - b;
                    valu_pkg::OP_MIN: r = lt ? a : b;
                    valu_pkg::OP_MAX: r = lt ? b : a;
                    valu_pkg::OP_AND: r = a & b;
                    valu_pkg::OP_OR:  r = a | b;
                    valu_pkg::OP_XOR: r = a ^ b;
                    valu_pkg::OP_SHL: r = a << shamt;
                    valu_pkg::OP_SHR: r = shr_ext[EW-1:0];
                    default:          r = '0;
                endcase
            end

            assign sew_result[s][e*EW +: EW] = r;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // width select and output register
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        result_next = sew_result[dec_sew];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_op_ok  <= (dec_op != valu_pkg::OP_NONE);
            ex_result <= result_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/valu_pkg.sv
`default_nettype none

package valu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data path types
    ////////////////////////////////////////////////////////////////////////////

    // one operand or result word.
    typedef logic [63:0] data_t;

    // one byte enable per byte of data_t.
    typedef logic [7:0] be_t;

    // element width code.
    typedef logic [1:0] sew_t;

    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;
    localparam sew_t SEW_64 = 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // function codes
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [5:0] func_t;

    localparam func_t FUNC_ADD  = 6'b000000;
    localparam func_t FUNC_SUB  = 6'b000010;
    localparam func_t FUNC_MINU = 6'b000100;
    localparam func_t FUNC_MIN  = 6'b000101;
    localparam func_t FUNC_MAXU = 6'b000110;
    localparam func_t FUNC_MAX  = 6'b000111;
    localparam func_t FUNC_AND  = 6'b001001;
    localparam func_t FUNC_OR   = 6'b001010;
    localparam func_t FUNC_XOR  = 6'b001011;
    localparam func_t FUNC_SLL  = 6'b100101;
    localparam func_t FUNC_SRL  = 6'b101000;
    localparam func_t FUNC_SRA  = 6'b101001;

    // decoded operation class, signedness travels as a separate flag.
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_MIN,
        OP_MAX,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SHL,
        OP_SHR,
        OP_NONE
    } alu_op_e;

    // decode, execute and result each add one register stage.
    localparam int PIPE_LATENCY = 3;

endpackage

`default_nettype wire

// File: hdl/valu_result.sv
`default_nettype none

module valu_result #(
    parameter int ADDR_WIDTH = 32,
    parameter int VL_WIDTH   = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic [VL_WIDTH-1:0]   req_vl,
    input  valu_pkg::be_t         req_be,
    input  logic                  ex_valid,
    input  logic                  ex_op_ok,
    input  valu_pkg::data_t       ex_result,
    output logic                  resp_valid,
    output valu_pkg::data_t       resp_data,
    output logic [ADDR_WIDTH-1:0] resp_addr,
    output logic [VL_WIDTH-1:0]   resp_vl,
    output valu_pkg::be_t         resp_be
);

    // side-band delay line, stage 0 matches decode and stage 1 matches execute.
    logic [ADDR_WIDTH-1:0] s0_addr;
    logic [ADDR_WIDTH-1:0] s1_addr;
    logic [VL_WIDTH-1:0]   s0_vl;
    logic [VL_WIDTH-1:0]   s1_vl;
    valu_pkg::be_t         s0_be;
    valu_pkg::be_t         s1_be;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s0_addr <= req_addr;
            s0_vl   <= req_vl;
            s0_be   <= req_be;
        end
        s1_addr <= s0_addr;
        s1_vl   <= s0_vl;
        s1_be   <= s0_be;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= ex_valid;
        end
    end

    // unknown operations return no enabled bytes.
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            resp_data <= ex_result;
            resp_addr <= s1_addr;
            resp_vl   <= s1_vl;
            resp_be   <= ex_op_ok ? s1_be : '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/valu_top.sv
`default_nettype none

module valu_top #(
    parameter int ADDR_WIDTH = 32,
    parameter int VL_WIDTH   = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  valu_pkg::func_t       req_func_id,
    input  valu_pkg::sew_t        req_sew,
    input  valu_pkg::data_t       req_data0,
    input  valu_pkg::data_t       req_data1,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  valu_pkg::be_t         req_be,
    input  logic [VL_WIDTH-1:0]   req_vl,
    output logic                  resp_valid,
    output valu_pkg::data_t       resp_data,
    output logic [ADDR_WIDTH-1:0] resp_addr,
    output logic [VL_WIDTH-1:0]   resp_vl,
    output valu_pkg::be_t         resp_be
);

    logic              dec_valid;
    valu_pkg::alu_op_e dec_op;
    logic              dec_signed;
    logic              dec_arith_shift;
    valu_pkg::sew_t    dec_sew;
    valu_pkg::data_t   dec_data0;
    valu_pkg::data_t   dec_data1;
    logic              ex_valid;
    logic              ex_op_ok;
    valu_pkg::data_t   ex_result;

    valu_decode u_decode (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_func_id     (req_func_id),
        .req_sew         (req_sew),
        .req_data0       (req_data0),
        .req_data1       (req_data1),
        .dec_valid       (dec_valid),
        .dec_op          (dec_op),
        .dec_signed      (dec_signed),
        .dec_arith_shift (dec_arith_shift),
        .dec_sew         (dec_sew),
        .dec_data0       (dec_data0),
        .dec_data1       (dec_data1)
    );

    valu_execute u_execute (
        .clk             (clk),
        .rst             (rst),
        .dec_valid       (dec_valid),
        .dec_op          (dec_op),
        .dec_signed      (dec_signed),
        .dec_arith_shift (dec_arith_shift),
        .dec_sew         (dec_sew),
        .dec_data0       (dec_data0),
        .dec_data1       (dec_data1),
        .ex_valid        (ex_valid),
        .ex_op_ok        (ex_op_ok),
        .ex_result       (ex_result)
    );

    valu_result #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .VL_WIDTH   (VL_WIDTH)
    ) u_result (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_vl     (req_vl),
        .req_be     (req_be),
        .ex_valid   (ex_valid),
        .ex_op_ok   (ex_op_ok),
        .ex_result  (ex_result),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_addr  (resp_addr),
        .resp_vl    (resp_vl),
        .resp_be    (resp_be)
    );

endmodule

`default_nettype wire

// File: valu.f
hdl/valu_pkg.sv
hdl/valu_decode.sv
hdl/valu_execute.sv
hdl/valu_result.sv
hdl/valu_top.sv
verification/valu_tb_sva.sv
verification/valu_tb.sv

// File: verification/valu_tb.sv
`default_nettype none

module valu_tb;

    localparam int ADDR_WIDTH     = 32;
    localparam int VL_WIDTH       = 8;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  req_valid;
    valu_pkg::func_t       req_func_id;
    valu_pkg::sew_t        req_sew;
    valu_pkg::data_t       req_data0;
    valu_pkg::data_t       req_data1;
    logic [ADDR_WIDTH-1:0] req_addr;
    valu_pkg::be_t         req_be;
    logic [VL_WIDTH-1:0]   req_vl;
    logic                  resp_valid;
    valu_pkg::data_t       resp_data;
    logic [ADDR_WIDTH-1:0] resp_addr;
    logic [VL_WIDTH-1:0]   resp_vl;
    valu_pkg::be_t         resp_be;

    // expected responses, oldest first.
    valu_pkg::data_t       data_q [$];
    logic [ADDR_WIDTH-1:0] addr_q [$];
    logic [VL_WIDTH-1:0]   vl_q [$];
    valu_pkg::be_t         be_q [$];
    string                 name_q [$];
    int                    sent_q [$];
    int                    cycle_count = 0;

    valu_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .VL_WIDTH   (VL_WIDTH)
    ) u_valu_top (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_func_id (req_func_id),
        .req_sew     (req_sew),
        .req_data0   (req_data0),
        .req_data1   (req_data1),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_vl      (req_vl),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .resp_vl     (resp_vl),
        .resp_be     (resp_be)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic valu_pkg::data_t ref_alu(input valu_pkg::func_t func,
                                                input valu_pkg::sew_t sew,
                                                input valu_pkg::data_t a,
                                                input valu_pkg::data_t b,
                                                output logic known);
        int          w;
        int          n;
        int          i;
        logic [63:0] mask;
        logic [63:0] sign;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] er;
        logic [63:0] res;
        logic [5:0]  sh;
        w     = 8 << sew;
        n     = 64 / w;
        mask  = (64'd1 << w) - 64'd1;
        sign  = 64'd1 << (w - 1);
        known = 1'b1;
        res   = '0;
        for (i = 0; i < n; i++) begin
            ea = (a >> (i * w)) & mask;
            eb = (b >> (i * w)) & mask;
            sh = eb[5:0] & 6'(w - 1);
            // flipping the sign bit turns signed order into unsigned order.
            case (func)
                valu_pkg::FUNC_ADD:  er = (ea + eb) & mask;
                valu_pkg::FUNC_SUB:  er = (ea - eb) & mask;
                valu_pkg::FUNC_MINU: er = (ea < eb) ? ea : eb;
                valu_pkg::FUNC_MIN:  er = ((ea ^ sign) < (eb ^ sign)) ? ea : eb;
                valu_pkg::FUNC_MAXU: er = (ea > eb) ? ea : eb;
                valu_pkg::FUNC_MAX:  er = ((ea ^ sign) > (eb ^ sign)) ? ea : eb;
                valu_pkg::FUNC_AND:  er = ea & eb;
                valu_pkg::FUNC_OR:   er = ea | eb;
                valu_pkg::FUNC_XOR:  er = ea ^ eb;
                valu_pkg::FUNC_SLL:  er = (ea << sh) & mask;
                valu_pkg::FUNC_SRL:  er = ea >> sh;
                valu_pkg::FUNC_SRA: begin
                    er = ea >> sh;
                    if ((ea & sign) != 0) begin
                        er = er | (mask & ~(mask >> sh));
                    end
                end
                default: begin
                    er    = '0;
                    known = 1'b0;
                end
            endcase
            res = res | (er << (i * w));
        end
        return res;
    endfunction

    // value one in every element.
    function automatic valu_pkg::data_t lane_ones(input valu_pkg::sew_t sew);
        case (sew)
            valu_pkg::SEW_8:  return 64'h0101_0101_0101_0101;
            valu_pkg::SEW_16: return 64'h0001_0001_0001_0001;
            valu_pkg::SEW_32: return 64'h0000_0001_0000_0001;
            default:          return 64'h0000_0000_0000_0001;
        endcase
    endfunction

    function automatic valu_pkg::func_t pick_func(input int unsigned idx);
        case (idx)
            0:       return valu_pkg::FUNC_ADD;
            1:       return valu_pkg::FUNC_SUB;
            2:       return valu_pkg::FUNC_MINU;
            3:       return valu_pkg::FUNC_MIN;
            4:       return valu_pkg::FUNC_MAXU;
            5:       return valu_pkg::FUNC_MAX;
            6:       return valu_pkg::FUNC_AND;
            7:       return valu_pkg::FUNC_OR;
            8:       return valu_pkg::FUNC_XOR;
            9:       return valu_pkg::FUNC_SLL;
            10:      return valu_pkg::FUNC_SRL;
            11:      return valu_pkg::FUNC_SRA;
            default: return 6'b111110;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic send(input string name, input valu_pkg::func_t func,
                        input valu_pkg::sew_t sew, input valu_pkg::data_t d0,
                        input valu_pkg::data_t d1);
        valu_pkg::data_t exp_data;
        logic            known;
        req_valid   = 1'b1;
        req_func_id = func;
        req_sew     = sew;
        req_data0   = d0;
        req_data1   = d1;
        req_addr    = ADDR_WIDTH'($urandom);
        req_vl      = VL_WIDTH'($urandom);
        req_be      = 8'($urandom);
        exp_data    = ref_alu(func, sew, d0, d1, known);
        data_q.push_back(exp_data);
        addr_q.push_back(req_addr);
        vl_q.push_back(req_vl);
        be_q.push_back(known ? req_be : 8'h00);
        name_q.push_back($sformatf("%s func=%b sew=%0d", name, func, sew));
        sent_q.push_back(cycle_count);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        req_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // timeout and response checking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // responses are read half a cycle after they are registered.
    always @(negedge clk) begin : compare
        string name;
        if (resp_valid) begin
            if (data_q.size() == 0) begin
                $display("unexpected response: resp_valid high with no request outstanding");
                $display("Testbench failed");
                $fatal(1, "unexpected response");
            end else begin
                name = name_q.pop_front();
                check_value({name, " data"}, data_q.pop_front(), resp_data);
                check_value({name, " addr"}, 64'(addr_q.pop_front()), 64'(resp_addr));
                check_value({name, " vl"}, 64'(vl_q.pop_front()), 64'(resp_vl));
                check_value({name, " be"}, 64'(be_q.pop_front()), 64'(resp_be));
                check_value({name, " latency"}, 64'(valu_pkg::PIPE_LATENCY),
                            64'(cycle_count - sent_q.pop_front()));
            end
        end
    end

    initial begin : stimulus
        valu_pkg::sew_t  sew;
        valu_pkg::data_t d0;
        valu_pkg::data_t d1;
        int              s;
        int              k;
        void'($urandom(32'hf1ab3bd9));
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_func_id = '0;
        req_sew     = '0;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_vl      = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // carries and borrows stay inside each element.
        for (s = 0; s < 4; s++) begin
            sew = valu_pkg::sew_t'(s);
            d0  = {$urandom, $urandom};
            d1  = {$urandom, $urandom};
            send("add ones", valu_pkg::FUNC_ADD, sew, '1, '1);
            send("add carry", valu_pkg::FUNC_ADD, sew, '1, lane_ones(sew));
            send("sub borrow", valu_pkg::FUNC_SUB, sew, '0, lane_ones(sew));
            send("add rand", valu_pkg::FUNC_ADD, sew, d0, d1);
            send("sub rand", valu_pkg::FUNC_SUB, sew, d0, d1);
        end

        // top bits differ in every element at every width.
        for (s = 0; s < 4; s++) begin
            sew = valu_pkg::sew_t'(s);
            for (k = 0; k < 4; k++) begin
                send("minmax mixed", pick_func(2 + k), sew,
                     64'h807f_ff00_8101_c040, 64'h7f80_00ff_0181_40c0);
                send("minmax rand", pick_func(2 + k), sew,
                     {$urandom, $urandom}, {$urandom, $urandom});
            end
        end

        d0 = {$urandom, $urandom};
        d1 = {$urandom, $urandom};
        for (s = 0; s < 4; s++) begin
            for (k = 0; k < 3; k++) begin
                send("logic", pick_func(6 + k), valu_pkg::sew_t'(s), d0, d1);
            end
        end

        // shift amounts of zero, maximum and random.
        for (s = 0; s < 4; s++) begin
            sew = valu_pkg::sew_t'(s);
            for (k = 0; k < 3; k++) begin
                send("shift zero", pick_func(9 + k), sew, 64'hf0e1_d2c3_b4a5_9687, '0);
                send("shift max", pick_func(9 + k), sew, 64'hf0e1_d2c3_b4a5_9687, '1);
                send("shift rand", pick_func(9 + k), sew,
                     {$urandom, $urandom}, {$urandom, $urandom});
            end
        end

        send("unknown", 6'b111111, valu_pkg::SEW_8, {$urandom, $urandom}, '1);
        send("unknown", 6'b000001, valu_pkg::SEW_64, {$urandom, $urandom}, '1);

        for (k = 0; k < 200; k++) begin
            if ($urandom % 4 == 0) begin
                idle_cycle();
            end
            send("burst", pick_func($urandom % 13), valu_pkg::sew_t'($urandom % 4),
                 {$urandom, $urandom}, {$urandom, $urandom});
        end

        while (data_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/valu_tb_sva.sv
`default_nettype none

module valu_tb_sva (
    input logic            clk,
    input logic            rst,
    input logic            req_valid,
    input valu_pkg::func_t req_func_id,
    input logic            resp_valid,
    input valu_pkg::be_t   resp_be
);

    logic func_known;

    always_comb begin
        func_known = req_func_id inside {
            valu_pkg::FUNC_ADD, valu_pkg::FUNC_SUB, valu_pkg::FUNC_MINU,
            valu_pkg::FUNC_MIN, valu_pkg::FUNC_MAXU, valu_pkg::FUNC_MAX,
            valu_pkg::FUNC_AND, valu_pkg::FUNC_OR, valu_pkg::FUNC_XOR,
            valu_pkg::FUNC_SLL, valu_pkg::FUNC_SRL, valu_pkg::FUNC_SRA
        };
    end

    a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !resp_valid)
        else $error("resp_valid high while in reset");

    a_latency: assert property (@(posedge clk) disable iff (rst)
        resp_valid == $past(req_valid, valu_pkg::PIPE_LATENCY))
        else $error("resp_valid does not follow req_valid by the pipeline latency");

    // unknown function codes must come back with no enabled bytes.
    a_unknown_be: assert property (@(posedge clk) disable iff (rst)
        resp_valid && $past(req_valid && !func_known, valu_pkg::PIPE_LATENCY)
        |-> resp_be == '0)
        else $error("resp_be not zero for an unknown function code");

endmodule

bind valu_top valu_tb_sva u_valu_tb_sva (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_func_id (req_func_id),
    .resp_valid  (resp_valid),
    .resp_be     (resp_be)
);

`default_nettype wire
